// ==== compile.f ====
+incdir+logic
logic/ahb_pkg.sv
logic/capture_pkg.sv
logic/wdata_gen.sv
logic/attr_gate.sv
logic/ahb_master_port.sv
logic/capture_ram.sv
logic/ahb_capture_top.sv
tests/ahb_slave_model.sv
tests/tb_ahb_capture.sv

// ==== logic/ahb_capture_top.sv ====
module ahb_capture_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  ahb_pkg::haddr_t       cmd_addr,
    input  logic                  cmd_write,
    input  capture_pkg::cap_idx_t cmd_slot,
    input  ahb_pkg::hdata_t       a,
    input  ahb_pkg::hdata_t       b,
    input  ahb_pkg::hsize_t       size,
    input  logic                  size_en,
    input  ahb_pkg::hburst_t      burst,
    input  logic                  burst_en,
    input  ahb_pkg::hprot_t       prot,
    input  logic                  prot_en,
    output logic                  rsp_valid,
    output logic                  rsp_error,
    output ahb_pkg::hdata_t       rsp_rdata,
    output ahb_pkg::haddr_t       haddr,
    output ahb_pkg::htrans_t      htrans,
    output logic                  hwrite,
    output ahb_pkg::hsize_t       hsize,
    output ahb_pkg::hburst_t      hburst,
    output ahb_pkg::hprot_t       hprot,
    output ahb_pkg::hdata_t       hwdata,
    input  ahb_pkg::hdata_t       hrdata,
    input  logic                  hready,
    input  logic                  hresp,
    input  capture_pkg::cap_idx_t rd_idx,
    input  logic                  clear,
    output ahb_pkg::hdata_t       data_out
);
    import ahb_pkg::*;
    import capture_pkg::*;

    logic     cmd_take;
    hdata_t   wdata;
    hsize_t   hsize_q;
    hburst_t  hburst_q;
    hprot_t   hprot_q;
    logic     cap_we;
    cap_idx_t cap_idx;
    hdata_t   cap_wdata;

    wdata_gen u_wdata_gen (
        .clk      (clk),
        .rst      (rst),
        .cmd_take (cmd_take),
        .a        (a),
        .b        (b),
        .wdata    (wdata)
    );

    attr_gate u_attr_gate (
        .clk      (clk),
        .rst      (rst),
        .cmd_take (cmd_take),
        .size     (size),
        .size_en  (size_en),
        .burst    (burst),
        .burst_en (burst_en),
        .prot     (prot),
        .prot_en  (prot_en),
        .hsize_q  (hsize_q),
        .hburst_q (hburst_q),
        .hprot_q  (hprot_q)
    );

    ahb_master_port u_master (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_addr  (cmd_addr),
        .cmd_write (cmd_write),
        .cmd_slot  (cmd_slot),
        .cmd_take  (cmd_take),
        .rsp_valid (rsp_valid),
        .rsp_error (rsp_error),
        .rsp_rdata (rsp_rdata),
        .wdata     (wdata),
        .hsize_q   (hsize_q),
        .hburst_q  (hburst_q),
        .hprot_q   (hprot_q),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hburst    (hburst),
        .hprot     (hprot),
        .hwdata    (hwdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp),
        .cap_we    (cap_we),
        .cap_idx   (cap_idx),
        .cap_wdata (cap_wdata)
    );

    capture_ram u_capture (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .cap_we    (cap_we),
        .cap_idx   (cap_idx),
        .cap_wdata (cap_wdata),
        .rd_idx    (rd_idx),
        .data_out  (data_out)
    );

endmodule

// ==== logic/ahb_defines.svh ====
`ifndef AHB_DEFINES_SVH
`define AHB_DEFINES_SVH

// Bus widths.
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Capture buffer holds 2**CAP_DEPTH_LOG2 words.
`define CAP_DEPTH_LOG2 10

// Attribute values used when a field's enable is low.
`define DEFAULT_SIZE  3'b010
`define DEFAULT_BURST 3'b000
`define DEFAULT_PROT  4'b0001

`endif

// ==== logic/ahb_master_port.sv ====
module ahb_master_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  ahb_pkg::haddr_t       cmd_addr,
    input  logic                  cmd_write,
    input  capture_pkg::cap_idx_t cmd_slot,
    output logic                  cmd_take,
    output logic                  rsp_valid,
    output logic                  rsp_error,
    output ahb_pkg::hdata_t       rsp_rdata,
    input  ahb_pkg::hdata_t       wdata,
    input  ahb_pkg::hsize_t       hsize_q,
    input  ahb_pkg::hburst_t      hburst_q,
    input  ahb_pkg::hprot_t       hprot_q,
    output ahb_pkg::haddr_t       haddr,
    output ahb_pkg::htrans_t      htrans,
    output logic                  hwrite,
    output ahb_pkg::hsize_t       hsize,
    output ahb_pkg::hburst_t      hburst,
    output ahb_pkg::hprot_t       hprot,
    output ahb_pkg::hdata_t       hwdata,
    input  ahb_pkg::hdata_t       hrdata,
    input  logic                  hready,
    input  logic                  hresp,
    output logic                  cap_we,
    output capture_pkg::cap_idx_t cap_idx,
    output ahb_pkg::hdata_t       cap_wdata
);
    import ahb_pkg::*;
    import capture_pkg::*;

    master_state_t state;
    haddr_t        addr_q;
    logic          write_q;
    cap_idx_t      slot_q;
    logic          done;

    assign cmd_ready = (state == M_IDLE);
    assign cmd_take  = cmd_valid && cmd_ready;
    assign done      = (state == M_DATA) && hready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= M_IDLE;
        end else begin
            case (state)
                M_IDLE:  if (cmd_take) state <= M_ADDR;
                M_ADDR:  state <= M_DATA;
                M_DATA:  if (hready) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
        end
    end

    // Command fields stay put until the next acceptance.
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            addr_q  <= cmd_addr;
            write_q <= cmd_write;
            slot_q  <= cmd_slot;
        end
    end

    assign haddr  = addr_q;
    assign htrans = (state == M_ADDR) ? NONSEQ : IDLE;
    assign hwrite = (state == M_ADDR) && write_q;
    assign hsize  = hsize_q;
    assign hburst = hburst_q;
    assign hprot  = hprot_q;
    assign hwdata = wdata;              // Stable across the whole data phase.

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            cap_we    <= 1'b0;
        end else begin
            rsp_valid <= done;
            cap_we    <= done && !write_q && !hresp;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp_error <= hresp;
            rsp_rdata <= hrdata;
        end
    end

    assign cap_idx   = slot_q;
    assign cap_wdata = rsp_rdata;

    a_nonseq_in_addr: assert property (@(posedge clk) disable iff (rst)
        (htrans == NONSEQ) |-> $past(cmd_take));

    a_rsp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |=> !rsp_valid);

endmodule

// ==== logic/ahb_pkg.sv ====
`include "ahb_defines.svh"

package ahb_pkg;

    typedef logic [`AHB_ADDR_W-1:0] haddr_t;
    typedef logic [`AHB_DATA_W-1:0] hdata_t;

    typedef logic [2:0] hsize_t;   // Bytes per beat as log2.
    typedef logic [2:0] hburst_t;
    typedef logic [3:0] hprot_t;

    // Transfer type on HTRANS.
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

endpackage

// ==== logic/attr_gate.sv ====
`include "ahb_defines.svh"

module attr_gate (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_take,
    input  ahb_pkg::hsize_t  size,
    input  logic             size_en,
    input  ahb_pkg::hburst_t burst,
    input  logic             burst_en,
    input  ahb_pkg::hprot_t  prot,
    input  logic             prot_en,
    output ahb_pkg::hsize_t  hsize_q,
    output ahb_pkg::hburst_t hburst_q,
    output ahb_pkg::hprot_t  hprot_q
);
    import ahb_pkg::*;

    localparam hsize_t WORD_SIZE = hsize_t'($clog2(`AHB_DATA_W / 8));

    hsize_t size_sel;

    always_comb begin
        size_sel = size_en ? size : hsize_t'(`DEFAULT_SIZE);
        if (size_sel > WORD_SIZE) begin
            size_sel = WORD_SIZE;          // No beat wider than the bus.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hsize_q  <= hsize_t'(`DEFAULT_SIZE);
            hburst_q <= hburst_t'(`DEFAULT_BURST);
            hprot_q  <= hprot_t'(`DEFAULT_PROT);
        end else if (cmd_take) begin
            hsize_q  <= size_sel;
            hburst_q <= burst_en ? burst : hburst_t'(`DEFAULT_BURST);
            hprot_q  <= prot_en ? prot : hprot_t'(`DEFAULT_PROT);
        end
    end

    a_size_in_range: assert property (@(posedge clk) disable iff (rst)
        cmd_take |=> (hsize_q <= WORD_SIZE)
            && (!$past(size_en) || ($past(size) > WORD_SIZE) || (hsize_q == $past(size))));

endmodule

// ==== logic/capture_pkg.sv ====
`include "ahb_defines.svh"

package capture_pkg;

    typedef logic [`CAP_DEPTH_LOG2-1:0] cap_idx_t;

    // Master port sequencing, one transfer at a time.
    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_DATA
    } master_state_t;

endpackage

// ==== logic/capture_ram.sv ====
`include "ahb_defines.svh"

module capture_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  cap_we,
    input  capture_pkg::cap_idx_t cap_idx,
    input  ahb_pkg::hdata_t       cap_wdata,
    input  capture_pkg::cap_idx_t rd_idx,
    output ahb_pkg::hdata_t       data_out
);
    import ahb_pkg::*;

    localparam int DEPTH = 1 << `CAP_DEPTH_LOG2;

    hdata_t           mem [DEPTH];
    logic [DEPTH-1:0] valid;

    always_ff @(posedge clk) begin
        if (cap_we) begin
            mem[cap_idx] <= cap_wdata;
        end
    end

    // Clear has priority over a write in the same cycle.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= '0;
        end else if (cap_we) begin
            valid[cap_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= valid[rd_idx] ? mem[rd_idx] : '0;  // Stale entries read zero.
    end

endmodule

// ==== logic/wdata_gen.sv ====
module wdata_gen (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_take,
    input  ahb_pkg::hdata_t a,
    input  ahb_pkg::hdata_t b,
    output ahb_pkg::hdata_t wdata
);

    // Sum wraps at the bus width and is held until the next command.
    always_ff @(posedge clk) begin
        if (rst) begin
            wdata <= '0;
        end else if (cmd_take) begin
            wdata <= a + b;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_ahb_capture
./obj_dir/Vtb_ahb_capture | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi

// ==== tests/ahb_slave_model.sv ====
module ahb_slave_model #(
    parameter ahb_pkg::haddr_t ERR_BASE = 32'h0000_0800
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wait_en,
    input  ahb_pkg::haddr_t  haddr,
    input  ahb_pkg::htrans_t htrans,
    input  logic             hwrite,
    input  ahb_pkg::hsize_t  hsize,
    input  ahb_pkg::hburst_t hburst,
    input  ahb_pkg::hprot_t  hprot,
    input  ahb_pkg::hdata_t  hwdata,
    output ahb_pkg::hdata_t  hrdata,
    output logic             hready,
    output logic             hresp
);
    import ahb_pkg::*;

    integer     seed = 32'h97e2;
    hdata_t     mem [256];
    logic       busy, write_q, err_q;
    logic [7:0] word_q;
    int         wait_cnt;

    // Attributes of the latest address phase.
    haddr_t  last_addr;
    logic    last_write;
    hsize_t  last_size;
    hburst_t last_burst;
    hprot_t  last_prot;
    int      last_wait;

    assign hready = !busy || (wait_cnt == 0);
    assign hresp  = busy && err_q && (wait_cnt <= 1);   // Two-cycle ERROR response.
    assign hrdata = busy ? mem[word_q] : '0;

    always @(posedge clk) begin
        int w;
        if (rst) begin
            busy     <= 1'b0;
            wait_cnt <= 0;
            for (int i = 0; i < 256; i++) begin
                mem[i[7:0]] <= 32'h5a00_0000 | (i << 2);   // Byte address in the low bits.
            end
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy <= 1'b0;
                if (write_q && !err_q) begin
                    mem[word_q] <= hwdata;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (htrans == NONSEQ) begin
            w = wait_en ? ($random(seed) & 3) : 0;
            if (haddr >= ERR_BASE && w == 0) begin
                w = 1;                                  // Room for the first ERROR cycle.
            end
            busy       <= 1'b1;
            write_q    <= hwrite;
            err_q      <= (haddr >= ERR_BASE);
            word_q     <= haddr[9:2];
            wait_cnt   <= w;
            last_addr  <= haddr;
            last_write <= hwrite;
            last_size  <= hsize;
            last_burst <= hburst;
            last_prot  <= hprot;
            last_wait  <= w;
        end
    end

endmodule

// ==== tests/tb_ahb_capture.sv ====
module tb_ahb_capture;
    import ahb_pkg::*;
    import capture_pkg::*;

    localparam haddr_t ERR_BASE = 32'h0000_0800;
    localparam int N_XFERS  = 39;
    localparam int XFER_MAX = 8;        // Accept, 3 base cycles, 3 waits, one gap.
    localparam int TIMEOUT_CYCLES = 8 + N_XFERS * XFER_MAX + 1034 + 200;

    logic     clk, rst, cmd_valid, cmd_ready, cmd_write, rsp_valid, rsp_error;
    logic     size_en, burst_en, prot_en, hwrite, hready, hresp, clear, wait_en;
    haddr_t   cmd_addr, haddr;
    hdata_t   a, b, rsp_rdata, hwdata, hrdata, data_out;
    hsize_t   size, hsize;
    hburst_t  burst, hburst;
    hprot_t   prot, hprot;
    htrans_t  htrans;
    cap_idx_t cmd_slot, rd_idx;

    integer seed = 32'h97e2;
    int     test_errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycles = 0;

    ahb_capture_top u_dut (.*);
    ahb_slave_model #(.ERR_BASE(ERR_BASE)) u_slave (.*);

    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
        if (got !== expected) begin
            $display("** Error at time %0t: %s, got %h, expected %h",
                     $time, what, got, expected);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // One command through the bridge, checking handshake, latency and response.
    task automatic transfer(input haddr_t addr, input logic wr, input hdata_t av,
                            input hdata_t bv, input cap_idx_t slot,
                            input logic exp_err, input hdata_t exp_rdata);
        int lat = 1;
        {cmd_valid, cmd_addr, cmd_write, cmd_slot, a, b} = {1'b1, addr, wr, slot, av, bv};
        while (!cmd_ready) begin
            next_cycle();
        end
        next_cycle();
        cmd_valid = 1'b0;
        while (!rsp_valid) begin
            compare(32'(cmd_ready), 32'd0, "cmd_ready low while busy");
            next_cycle();
            lat++;
        end
        compare(32'(cmd_ready), 32'd1, "cmd_ready back with rsp_valid");
        compare(32'(lat), 32'(3 + u_slave.last_wait), "response latency");
        compare(u_slave.last_addr, addr, "address phase haddr");
        compare(32'(u_slave.last_write), 32'(wr), "address phase hwrite");
        compare(32'(rsp_error), 32'(exp_err), "rsp_error");
        if (!wr && !exp_err) begin
            compare(rsp_rdata, exp_rdata, "rsp_rdata");
        end
        next_cycle();
        compare(32'(rsp_valid), 32'd0, "rsp_valid single pulse");
    endtask

    task automatic read_slot(input cap_idx_t idx, output hdata_t data);
        rd_idx = idx;
        next_cycle();
        data = data_out;
    endtask

    task automatic attr_case(input logic [12:0] fields, input logic [9:0] expected);
        {size, size_en, burst, burst_en, prot, prot_en} = fields;
        transfer(32'h80, 1'b1, 32'd1, 32'd2, '0, 1'b0, '0);
        compare(32'({u_slave.last_size, u_slave.last_burst, u_slave.last_prot}),
                32'(expected), "recorded size, burst, prot");
    endtask

    task automatic test_reset();
        hdata_t d;
        compare(32'(cmd_ready), 32'd1, "cmd_ready after reset");
        compare(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        compare(32'(htrans), 32'(IDLE), "htrans after reset");
        compare(32'(hwrite), 32'd0, "hwrite after reset");
        for (int i = 0; i < 4; i++) begin
            read_slot(cap_idx_t'(i * 341), d);
            compare(d, 32'd0, "capture entry after reset");
        end
        end_test("reset_state");
    endtask

    task automatic test_write_read();
        hdata_t av, bv;
        wait_en = 1'b0;
        transfer(32'h10, 1'b1, 32'hffff_fff0, 32'h20, '0, 1'b0, '0);
        transfer(32'h10, 1'b0, '0, '0, 10'd1, 1'b0, 32'h10);     // Sum wraps.
        for (int i = 0; i < 4; i++) begin
            av = $random(seed);
            bv = $random(seed);
            transfer(haddr_t'(32'h40 + i * 8), 1'b1, av, bv, '0, 1'b0, '0);
            transfer(haddr_t'(32'h40 + i * 8), 1'b0, '0, '0, cap_idx_t'(2 + i), 1'b0, av + bv);
        end
        end_test("write_read");
    endtask

    task automatic test_attributes();
        attr_case({3'd0, 1'b1, 3'd3, 1'b1, 4'hf, 1'b1}, {3'd0, 3'd3, 4'hf});
        attr_case({3'd1, 1'b0, 3'd5, 1'b0, 4'h2, 1'b0}, {3'd2, 3'd0, 4'h1});
        attr_case({3'd1, 1'b1, 3'd1, 1'b1, 4'h3, 1'b0}, {3'd1, 3'd1, 4'h1});
        attr_case({3'd3, 1'b1, 3'd7, 1'b0, 4'ha, 1'b1}, {3'd2, 3'd0, 4'ha});
        attr_case({3'd7, 1'b1, 3'd2, 1'b1, 4'h0, 1'b1}, {3'd2, 3'd2, 4'h0});
        {size, size_en, burst, burst_en, prot, prot_en} = {3'd2, 1'b0, 3'd0, 1'b0, 4'h1, 1'b0};
        end_test("attributes");
    endtask

    task automatic test_wait_states();
        hdata_t av, bv;
        haddr_t addr;
        int     waits = 0;
        wait_en = 1'b1;
        for (int i = 0; i < 6; i++) begin
            av = $random(seed);
            bv = $random(seed);
            addr = {22'd0, 8'($random(seed)), 2'b00};
            transfer(addr, 1'b1, av, bv, '0, 1'b0, '0);
            waits += u_slave.last_wait;
            transfer(addr, 1'b0, '0, '0, cap_idx_t'(20 + i), 1'b0, av + bv);
        end
        compare(32'(waits > 0), 32'd1, "wait states inserted");
        end_test("wait_states");
    endtask

    task automatic test_error();
        hdata_t d;
        transfer(ERR_BASE + 32'h10, 1'b0, '0, '0, 10'd700, 1'b1, '0);
        read_slot(10'd700, d);
        compare(d, 32'd0, "slot after error read");
        transfer(ERR_BASE, 1'b1, 32'd5, 32'd6, '0, 1'b1, '0);
        transfer(32'h3fc, 1'b1, 32'h1234_0000, 32'h5678, '0, 1'b0, '0);
        transfer(32'h3fc, 1'b0, '0, '0, 10'd701, 1'b0, 32'h1234_5678);
        end_test("error_response");
    endtask

    task automatic test_capture_clear();
        hdata_t vals [$];
        hdata_t d;
        for (int i = 0; i < 4; i++) begin
            vals.push_back($random(seed));
            transfer(haddr_t'(32'h200 + i * 4), 1'b1, vals[i], 32'd0, '0, 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            transfer(haddr_t'(32'h200 + i * 4), 1'b0, '0, '0, cap_idx_t'(3 + i * 340),
                     1'b0, vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            read_slot(cap_idx_t'(3 + i * 340), d);
            compare(d, vals[i], "captured word");
        end
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            read_slot(cap_idx_t'(i), d);
            compare(d, 32'd0, "entry after clear");
        end
        end_test("capture_clear");
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: simulation still running after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        {clk, rst, cmd_valid, cmd_write, clear, wait_en} = 6'b010000;
        {cmd_addr, cmd_slot, a, b, rd_idx} = '0;
        {size, size_en, burst, burst_en, prot, prot_en} = {3'd2, 1'b0, 3'd0, 1'b0, 4'h1, 1'b0};
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_write_read();
        test_attributes();
        test_wait_states();
        test_error();
        test_capture_clear();
        $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
